//--- hw/dcache_pkg.sv
package dcache_pkg;

    // cache geometry
    localparam int line_words  = 8;
    localparam int word_bytes  = 4;
    localparam int num_sets    = 8;
    localparam int offset_bits = 5;   // byte offset within a line
    localparam int index_bits  = 3;
    localparam int tag_bits    = 24;

    typedef logic [31:0]                 word_t;
    typedef logic [31:0]                 addr_t;
    typedef logic [word_bytes-1:0]       strb_t;
    typedef logic [tag_bits-1:0]         tag_t;
    typedef logic [index_bits-1:0]       index_t;
    typedef logic [2:0]                  woff_t;   // word in line, also burst beat
    typedef logic [line_words*32-1:0]    line_t;
    typedef logic [7:0]                  age_t;    // saturating lru age

    typedef enum logic [3:0] {
        idle,
        tag_check,
        access,
        respond,
        evict,
        refill_req,
        refill_recv,
        refill_write,
        wb_req,
        wb_send
    } ctrl_state_t;

endpackage

//--- hw/line_burst_buf.sv
`timescale 1ns/10ps

module line_burst_buf (
    input  logic              clk,
    input  logic              rst,
    input  logic              beat_clr,
    input  logic              load_line,
    input  dcache_pkg::line_t victim_line,
    input  logic              mem_rd_rsp_valid,
    input  logic              mem_rd_rsp_ready,
    input  logic              mem_rd_rsp_last,
    input  dcache_pkg::word_t mem_rd_rsp_data,
    input  logic              mem_wr_data_valid,
    input  logic              mem_wr_data_ready,
    output dcache_pkg::word_t mem_wr_data,
    output logic              mem_wr_data_last,
    output dcache_pkg::line_t buf_line,
    output logic              recv_done,
    output logic              send_done
);

    dcache_pkg::word_t words [dcache_pkg::line_words];
    dcache_pkg::woff_t beat;     // next beat position
    logic              rd_beat;
    logic              wr_beat;

    assign rd_beat = mem_rd_rsp_valid && mem_rd_rsp_ready;
    assign wr_beat = mem_wr_data_valid && mem_wr_data_ready;

    always_ff @(posedge clk) begin
        if (rst || beat_clr)
            beat <= '0;
        else if (rd_beat || wr_beat)
            beat <= beat + 1'b1;
    end

    // victim snapshot or one refill word per beat
    always_ff @(posedge clk) begin
        if (load_line) begin
            for (int i = 0; i < dcache_pkg::line_words; i++)
                words[i] <= victim_line[i * 32 +: 32];
        end else if (rd_beat) begin
            words[beat] <= mem_rd_rsp_data;
        end
    end

    always_comb begin
        for (int i = 0; i < dcache_pkg::line_words; i++)
            buf_line[i * 32 +: 32] = words[i];
    end

    assign mem_wr_data      = words[beat];
    assign mem_wr_data_last = mem_wr_data_valid &&
                              (beat == dcache_pkg::woff_t'(dcache_pkg::line_words - 1));

    assign recv_done = rd_beat && mem_rd_rsp_last;
    assign send_done = wr_beat && mem_wr_data_last;

endmodule

//--- hw/dcache_ways.sv
`timescale 1ns/10ps

module dcache_ways #(
    parameter int num_ways = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  dcache_pkg::index_t index,
    input  dcache_pkg::tag_t   tag,
    input  logic               look_up,
    input  logic               evict,
    input  logic               refill_wen,
    input  logic               write_wen,
    input  dcache_pkg::line_t  refill_line,
    input  dcache_pkg::line_t  write_line,
    output logic               hit,
    output logic               dirty_victim,
    output dcache_pkg::tag_t   victim_tag,
    output dcache_pkg::line_t  hit_line,
    output dcache_pkg::line_t  victim_line
);

    dcache_pkg::tag_t  tag_mem  [num_ways][dcache_pkg::num_sets];
    dcache_pkg::line_t line_mem [num_ways][dcache_pkg::num_sets];
    dcache_pkg::age_t  age_mem  [num_ways][dcache_pkg::num_sets];
    logic [dcache_pkg::num_sets-1:0] valid_bits [num_ways];
    logic [dcache_pkg::num_sets-1:0] dirty_bits [num_ways];

    logic [num_ways-1:0] hit_way;      // one-hot
    logic [num_ways-1:0] victim_way;   // one-hot
    dcache_pkg::age_t    victim_age;

    always_comb begin
        for (int w = 0; w < num_ways; w++)
            hit_way[w] = valid_bits[w][index] && (tag_mem[w][index] == tag);
    end

    assign hit = |hit_way;

    // oldest way goes, strict compare keeps the lowest way on ties
    always_comb begin
        victim_way    = '0;
        victim_way[0] = 1'b1;
        victim_age    = age_mem[0][index];
        for (int w = 1; w < num_ways; w++) begin
            if (age_mem[w][index] > victim_age) begin
                victim_age    = age_mem[w][index];
                victim_way    = '0;
                victim_way[w] = 1'b1;
            end
        end
    end

    always_comb begin
        hit_line     = '0;
        victim_line  = '0;
        victim_tag   = '0;
        dirty_victim = 1'b0;
        for (int w = 0; w < num_ways; w++) begin
            if (hit_way[w])
                hit_line = hit_line | line_mem[w][index];
            if (victim_way[w]) begin
                victim_line  = victim_line | line_mem[w][index];
                victim_tag   = victim_tag | tag_mem[w][index];
                dirty_victim = dirty_victim | (valid_bits[w][index] && dirty_bits[w][index]);
            end
        end
    end

    // tag and data storage
    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (refill_wen && victim_way[w]) begin
                tag_mem[w][index]  <= tag;
                line_mem[w][index] <= refill_line;
            end else if (write_wen && hit_way[w]) begin
                line_mem[w][index] <= write_line;
            end
        end
    end

    // valid, dirty and lru ages
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < num_ways; w++) begin
                valid_bits[w] <= '0;
                dirty_bits[w] <= '0;
                for (int s = 0; s < dcache_pkg::num_sets; s++)
                    age_mem[w][s] <= '0;
            end
        end else begin
            for (int w = 0; w < num_ways; w++) begin
                if (look_up) begin
                    if (hit_way[w])
                        age_mem[w][index] <= '0;
                    else if (age_mem[w][index] != '1)   // saturate
                        age_mem[w][index] <= dcache_pkg::age_t'(age_mem[w][index] + 1'b1);
                end
                if (evict && victim_way[w])
                    valid_bits[w][index] <= 1'b0;
                if (refill_wen && victim_way[w]) begin
                    valid_bits[w][index] <= 1'b1;
                    dirty_bits[w][index] <= 1'b0;
                    age_mem[w][index]    <= '0;   // fresh line counts as just used
                end
                if (write_wen && hit_way[w])
                    dirty_bits[w][index] <= 1'b1;
            end
        end
    end

endmodule

//--- hw/dcache_ctrl.sv
`timescale 1ns/10ps

module dcache_ctrl #(
    parameter int num_ways = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cpu_req_valid,
    input  logic               cpu_req_write,
    input  dcache_pkg::addr_t  cpu_req_addr,
    input  dcache_pkg::word_t  cpu_req_wdata,
    input  dcache_pkg::strb_t  cpu_req_wstrb,
    output logic               cpu_req_ready,
    output logic               cpu_rsp_valid,
    output dcache_pkg::word_t  cpu_rsp_data,
    input  logic               cpu_rsp_ready,
    output logic               mem_rd_req_valid,
    output dcache_pkg::addr_t  mem_rd_req_addr,
    input  logic               mem_rd_req_ready,
    output logic               mem_rd_rsp_ready,
    output logic               mem_wr_req_valid,
    output dcache_pkg::addr_t  mem_wr_req_addr,
    input  logic               mem_wr_req_ready,
    output logic               mem_wr_data_valid,
    input  logic               recv_done,
    input  logic               send_done,
    input  logic               hit,
    input  logic               dirty_victim,
    input  dcache_pkg::tag_t   victim_tag,
    input  dcache_pkg::line_t  hit_line,
    input  dcache_pkg::line_t  buf_line,
    output dcache_pkg::index_t index,
    output dcache_pkg::tag_t   tag,
    output logic               look_up,
    output logic               evict,
    output logic               refill_wen,
    output logic               write_wen,
    output dcache_pkg::line_t  write_line,
    output logic               beat_clr,
    output logic               load_line
);

    dcache_pkg::ctrl_state_t state;
    dcache_pkg::ctrl_state_t state_next;

    dcache_pkg::tag_t   req_tag;
    dcache_pkg::index_t req_index;
    dcache_pkg::woff_t  req_woff;
    logic               req_write;
    dcache_pkg::word_t  req_wdata;
    dcache_pkg::strb_t  req_strb;
    logic               from_refill;    // line arrived by refill, not found by lookup
    dcache_pkg::line_t  src_line;
    logic               accept;

    // way count has to make sense before anything else does
    if (num_ways < 1) begin : g_way_check
        $error("dcache_ctrl: num_ways must be at least 1");
    end

    assign accept = cpu_req_valid && cpu_req_ready;

    // request latch, split into tag / index / word offset
    always_ff @(posedge clk) begin
        if (accept) begin
            req_tag   <= cpu_req_addr[dcache_pkg::offset_bits + dcache_pkg::index_bits +:
                                      dcache_pkg::tag_bits];
            req_index <= cpu_req_addr[dcache_pkg::offset_bits +: dcache_pkg::index_bits];
            req_woff  <= cpu_req_addr[dcache_pkg::offset_bits-1 -: 3];
            req_write <= cpu_req_write;
            req_wdata <= cpu_req_wdata;
            req_strb  <= cpu_req_wstrb;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= dcache_pkg::idle;
            from_refill <= 1'b0;
        end else begin
            state <= state_next;
            if (accept)
                from_refill <= 1'b0;
            else if (state == dcache_pkg::refill_write)
                from_refill <= 1'b1;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            dcache_pkg::idle:         if (cpu_req_valid) state_next = dcache_pkg::tag_check;
            dcache_pkg::tag_check:    state_next = hit ? dcache_pkg::access : dcache_pkg::evict;
            dcache_pkg::access:       state_next = req_write ? dcache_pkg::idle
                                                             : dcache_pkg::respond;
            dcache_pkg::respond:      if (cpu_rsp_ready) state_next = dcache_pkg::idle;
            dcache_pkg::evict:        state_next = dirty_victim ? dcache_pkg::wb_req
                                                                : dcache_pkg::refill_req;
            dcache_pkg::wb_req:       if (mem_wr_req_ready) state_next = dcache_pkg::wb_send;
            dcache_pkg::wb_send:      if (send_done) state_next = dcache_pkg::refill_req;
            dcache_pkg::refill_req:   if (mem_rd_req_ready) state_next = dcache_pkg::refill_recv;
            dcache_pkg::refill_recv:  if (recv_done) state_next = dcache_pkg::refill_write;
            dcache_pkg::refill_write: state_next = req_write ? dcache_pkg::access  // write miss
                                                             : dcache_pkg::respond;
            default:                  state_next = dcache_pkg::idle;
        endcase
    end

    // cpu side
    assign cpu_req_ready = (state == dcache_pkg::idle);
    assign cpu_rsp_valid = (state == dcache_pkg::respond);
    assign src_line      = from_refill ? buf_line : hit_line;
    assign cpu_rsp_data  = src_line[{req_woff, 5'b0} +: 32];

    // memory side, always whole lines
    assign mem_rd_req_valid  = (state == dcache_pkg::refill_req);
    assign mem_rd_req_addr   = {req_tag, req_index, {dcache_pkg::offset_bits{1'b0}}};
    assign mem_rd_rsp_ready  = (state == dcache_pkg::refill_recv);
    assign mem_wr_req_valid  = (state == dcache_pkg::wb_req);
    assign mem_wr_req_addr   = {victim_tag, req_index, {dcache_pkg::offset_bits{1'b0}}};
    assign mem_wr_data_valid = (state == dcache_pkg::wb_send);

    // array and buffer commands
    assign index      = req_index;
    assign tag        = req_tag;
    assign look_up    = (state == dcache_pkg::tag_check);
    assign evict      = (state == dcache_pkg::evict);
    assign load_line  = (state == dcache_pkg::evict);    // snapshot victim for write-back
    assign refill_wen = (state == dcache_pkg::refill_write);
    assign write_wen  = (state == dcache_pkg::access) && req_write;
    assign beat_clr   = (state == dcache_pkg::refill_req) || (state == dcache_pkg::wb_req);

    // strobed byte merge into the line
    always_comb begin
        write_line = src_line;
        for (int b = 0; b < dcache_pkg::word_bytes; b++) begin
            if (req_strb[b])
                write_line[{req_woff, 5'b0} + b * 8 +: 8] = req_wdata[b * 8 +: 8];
        end
    end

endmodule

//--- hw/dcache_top.sv
`timescale 1ns/10ps

module dcache_top #(
    parameter int num_ways = 4
) (
    input  logic              clk,
    input  logic              rst,

    input  logic              cpu_req_valid,
    input  logic              cpu_req_write,
    input  dcache_pkg::addr_t cpu_req_addr,
    input  dcache_pkg::word_t cpu_req_wdata,
    input  dcache_pkg::strb_t cpu_req_wstrb,
    output logic              cpu_req_ready,
    output logic              cpu_rsp_valid,
    output dcache_pkg::word_t cpu_rsp_data,
    input  logic              cpu_rsp_ready,

    output logic              mem_rd_req_valid,
    output dcache_pkg::addr_t mem_rd_req_addr,
    input  logic              mem_rd_req_ready,
    input  logic              mem_rd_rsp_valid,
    input  logic              mem_rd_rsp_last,
    input  dcache_pkg::word_t mem_rd_rsp_data,
    output logic              mem_rd_rsp_ready,

    output logic              mem_wr_req_valid,
    output dcache_pkg::addr_t mem_wr_req_addr,
    input  logic              mem_wr_req_ready,
    output logic              mem_wr_data_valid,
    output logic              mem_wr_data_last,
    output dcache_pkg::word_t mem_wr_data,
    input  logic              mem_wr_data_ready
);

    // array side
    dcache_pkg::index_t index;
    dcache_pkg::tag_t   tag;
    logic               look_up;
    logic               evict;
    logic               refill_wen;
    logic               write_wen;
    dcache_pkg::line_t  write_line;
    logic               hit;
    logic               dirty_victim;
    dcache_pkg::tag_t   victim_tag;
    dcache_pkg::line_t  hit_line;
    dcache_pkg::line_t  victim_line;

    // burst buffer side
    logic               beat_clr;
    logic               load_line;
    dcache_pkg::line_t  buf_line;
    logic               recv_done;
    logic               send_done;

    dcache_ctrl #(
        .num_ways(num_ways)
    ) ctrl_i (.*);

    dcache_ways #(
        .num_ways(num_ways)
    ) ways_i (
        .clk          (clk),
        .rst          (rst),
        .index        (index),
        .tag          (tag),
        .look_up      (look_up),
        .evict        (evict),
        .refill_wen   (refill_wen),
        .write_wen    (write_wen),
        .refill_line  (buf_line),     // refill data comes straight from the burst buffer
        .write_line   (write_line),
        .hit          (hit),
        .dirty_victim (dirty_victim),
        .victim_tag   (victim_tag),
        .hit_line     (hit_line),
        .victim_line  (victim_line)
    );

    line_burst_buf buf_i (.*);

endmodule

//--- tests/dcache_chk.sv
`timescale 1ns/10ps

module dcache_chk (
    input logic              clk,
    input logic              rst,
    input logic              cpu_req_ready,
    input logic              cpu_rsp_valid,
    input logic              cpu_rsp_ready,
    input dcache_pkg::word_t cpu_rsp_data,
    input logic              mem_rd_req_valid,
    input logic              mem_wr_req_valid,
    input logic              mem_wr_data_valid,
    input logic              mem_wr_data_last
);

    // stalled response keeps its word
    rsp_hold: assert property (@(posedge clk) disable iff (rst)
        (cpu_rsp_valid && !cpu_rsp_ready) |=> (cpu_rsp_valid && $stable(cpu_rsp_data)))
        else $error("response dropped or changed under back-pressure");

    last_with_valid: assert property (@(posedge clk) disable iff (rst)
        mem_wr_data_last |-> mem_wr_data_valid)
        else $error("mem_wr_data_last without mem_wr_data_valid");

    one_mem_req: assert property (@(posedge clk) disable iff (rst)
        !(mem_rd_req_valid && mem_wr_req_valid))
        else $error("read and write-back requests raised together");

    idle_no_mem: assert property (@(posedge clk) disable iff (rst)
        cpu_req_ready |-> !(mem_rd_req_valid || mem_wr_req_valid))
        else $error("memory request while the cache is idle");   // idle means no miss

endmodule

bind dcache_top dcache_chk chk_i (
    .clk               (clk),
    .rst               (rst),
    .cpu_req_ready     (cpu_req_ready),
    .cpu_rsp_valid     (cpu_rsp_valid),
    .cpu_rsp_ready     (cpu_rsp_ready),
    .cpu_rsp_data      (cpu_rsp_data),
    .mem_rd_req_valid  (mem_rd_req_valid),
    .mem_wr_req_valid  (mem_wr_req_valid),
    .mem_wr_data_valid (mem_wr_data_valid),
    .mem_wr_data_last  (mem_wr_data_last)
);

//--- tests/dcache_tb.sv
`timescale 1ns/10ps

module dcache_tb;

    localparam int wait_limit  = 2000;   // cycles allowed per wait
    localparam int traffic_ops = 400;
    localparam int repeat_ops  = 24;

    logic              clk;
    logic              rst;
    logic              cpu_req_valid;
    logic              cpu_req_write;
    dcache_pkg::addr_t cpu_req_addr;
    dcache_pkg::word_t cpu_req_wdata;
    dcache_pkg::strb_t cpu_req_wstrb;
    logic              cpu_req_ready;
    logic              cpu_rsp_valid;
    dcache_pkg::word_t cpu_rsp_data;
    logic              cpu_rsp_ready;
    logic              mem_rd_req_valid;
    dcache_pkg::addr_t mem_rd_req_addr;
    logic              mem_rd_req_ready;
    logic              mem_rd_rsp_valid;
    logic              mem_rd_rsp_last;
    dcache_pkg::word_t mem_rd_rsp_data;
    logic              mem_rd_rsp_ready;
    logic              mem_wr_req_valid;
    dcache_pkg::addr_t mem_wr_req_addr;
    logic              mem_wr_req_ready;
    logic              mem_wr_data_valid;
    logic              mem_wr_data_last;
    dcache_pkg::word_t mem_wr_data;
    logic              mem_wr_data_ready;

    int errors   = 0;
    int checks   = 0;
    int wb_count = 0;
    logic [31:0] cpu_rng = 32'd44212;
    logic [31:0] mem_rng = 32'd44212 ^ 32'h2545_f491;   // own stream for the memory side

    dcache_pkg::word_t mem_model [dcache_pkg::addr_t];
    dcache_pkg::word_t shadow    [dcache_pkg::addr_t];  // what the cpu should read
    bit                wb_clean  [dcache_pkg::addr_t];  // memory copy of the line is current

    dcache_top #(.num_ways(4)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] cpu_word();
        cpu_rng = lcg_next(cpu_rng);
        return cpu_rng;
    endfunction

    function automatic int unsigned cpu_rand(input int unsigned n);
        return (cpu_word() >> 8) % n;
    endfunction

    function automatic int unsigned mem_rand(input int unsigned n);
        mem_rng = lcg_next(mem_rng);
        return (mem_rng >> 8) % n;
    endfunction

    // power-up content, every address bit matters
    function automatic dcache_pkg::word_t init_word(input dcache_pkg::addr_t a);
        return (a * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    function automatic dcache_pkg::word_t mem_word(input dcache_pkg::addr_t a);
        return mem_model.exists(a) ? mem_model[a] : init_word(a);
    endfunction

    function automatic dcache_pkg::word_t shadow_word(input dcache_pkg::addr_t a);
        return shadow.exists(a) ? shadow[a] : init_word(a);
    endfunction

    function automatic dcache_pkg::word_t merge_bytes(input dcache_pkg::word_t old_w,
                                                      input dcache_pkg::word_t new_w,
                                                      input dcache_pkg::strb_t strb);
        dcache_pkg::word_t r;
        r = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b])
                r[b * 8 +: 8] = new_w[b * 8 +: 8];
        end
        return r;
    endfunction

    // 8 tags over sets 2 and 5, more lines than ways
    function automatic dcache_pkg::addr_t pick_addr();
        dcache_pkg::tag_t   t;
        dcache_pkg::index_t s;
        dcache_pkg::woff_t  w;
        t = 24'h00a100 + 24'(cpu_rand(8)) * 24'h000131;
        s = (cpu_rand(2) == 0) ? 3'd2 : 3'd5;
        w = dcache_pkg::woff_t'(cpu_rand(8));
        return {t, s, w, 2'b00};
    endfunction

    task automatic check_word(input string what, input dcache_pkg::word_t got,
                              input dcache_pkg::word_t exp);
        checks++;
        assert (got === exp) else begin
            $display("FAILED @%0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_cond(input string what, input logic ok);
        checks++;
        assert (ok === 1'b1) else begin
            $display("FAILED @%0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic give_up(input string what);
        $display("timeout while waiting for %s", what);
        $display("=== FAIL ===");
        $finish;
    endtask

    task automatic report_test(input string name, input int start_errors);
        if (errors == start_errors)
            $display("test %-16s ok", name);
        else
            $display("test %-16s %0d errors", name, errors - start_errors);
    endtask

    // called on a falling edge, returns on a falling edge with the cache idle
    task automatic cpu_read(input dcache_pkg::addr_t a, output dcache_pkg::word_t data,
                            output int lat, output bit saw_mem);
        int n;
        int stall;
        cpu_req_valid = 1'b1;
        cpu_req_write = 1'b0;
        cpu_req_addr  = a;
        n = 0;
        while (!cpu_req_ready) begin
            @(negedge clk);
            if (++n > wait_limit) give_up("cpu_req_ready before a read");
        end
        saw_mem = 1'b0;
        @(negedge clk);                  // request taken on the edge just passed
        cpu_req_valid = 1'b0;
        lat = 1;
        while (!cpu_rsp_valid) begin
            if (mem_rd_req_valid || mem_wr_req_valid)
                saw_mem = 1'b1;
            @(negedge clk);
            if (++lat > wait_limit) give_up("cpu_rsp_valid");
        end
        data  = cpu_rsp_data;
        stall = cpu_rand(4);
        repeat (stall) begin
            @(negedge clk);
            check_cond("cpu_rsp_valid held while cpu_rsp_ready is low", cpu_rsp_valid);
            check_word("response data under back-pressure", cpu_rsp_data, data);
        end
        cpu_rsp_ready = 1'b1;
        @(negedge clk);
        cpu_rsp_ready = 1'b0;
    endtask

    task automatic cpu_write(input dcache_pkg::addr_t a, input dcache_pkg::word_t d,
                             input dcache_pkg::strb_t s);
        int n;
        cpu_req_valid = 1'b1;
        cpu_req_write = 1'b1;
        cpu_req_addr  = a;
        cpu_req_wdata = d;
        cpu_req_wstrb = s;
        n = 0;
        while (!cpu_req_ready) begin
            @(negedge clk);
            if (++n > wait_limit) give_up("cpu_req_ready before a write");
        end
        shadow[a] = merge_bytes(shadow_word(a), d, s);
        wb_clean[{a[31:5], 5'd0}] = 1'b0;
        @(negedge clk);
        cpu_req_valid = 1'b0;
        cpu_req_write = 1'b0;
        n = 0;
        while (!cpu_req_ready) begin
            @(negedge clk);
            if (++n > wait_limit) give_up("end of a write");
        end
    endtask

    task automatic serve_refill(input dcache_pkg::addr_t a);
        int n;
        check_cond("refill address is line aligned", a[4:0] == 5'd0);
        for (int beat = 0; beat < 8; beat++) begin
            repeat (mem_rand(3)) @(negedge clk);
            mem_rd_rsp_valid = 1'b1;
            mem_rd_rsp_data  = mem_word(a + dcache_pkg::addr_t'(beat * 4));
            mem_rd_rsp_last  = (beat == 7);
            n = 0;
            while (!mem_rd_rsp_ready) begin
                @(negedge clk);
                if (++n > wait_limit) give_up("mem_rd_rsp_ready");
            end
            @(negedge clk);
            mem_rd_rsp_valid = 1'b0;
            mem_rd_rsp_last  = 1'b0;
        end
    endtask

    // beats must match the shadow line as it stands now
    task automatic serve_writeback(input dcache_pkg::addr_t a);
        int beats;
        int n;
        dcache_pkg::addr_t wa;
        check_cond("write-back address is line aligned", a[4:0] == 5'd0);
        beats = 0;
        n = 0;
        while (beats < 8) begin
            mem_wr_data_ready = (mem_rand(4) != 0);
            if (mem_wr_data_valid && mem_wr_data_ready) begin
                wa = a + dcache_pkg::addr_t'(beats * 4);
                check_word("write-back beat", mem_wr_data, shadow_word(wa));
                check_cond($sformatf("mem_wr_data_last on beat %0d", beats + 1),
                           mem_wr_data_last == (beats == 7));
                mem_model[wa] = mem_wr_data;
                beats++;
                n = 0;
            end else if (++n > wait_limit) begin
                give_up("write-back beat");
            end
            @(negedge clk);
        end
        mem_wr_data_ready = 1'b0;
        check_cond("write-back ends after 8 beats", !mem_wr_data_valid);
        wb_clean[a] = 1'b1;
        wb_count++;
    endtask

    initial begin : mem_side
        dcache_pkg::addr_t a;
        mem_rd_req_ready  = 1'b0;
        mem_rd_rsp_valid  = 1'b0;
        mem_rd_rsp_last   = 1'b0;
        mem_rd_rsp_data   = '0;
        mem_wr_req_ready  = 1'b0;
        mem_wr_data_ready = 1'b0;
        @(negedge clk);
        forever begin
            mem_rd_req_ready = (mem_rand(4) != 0);
            mem_wr_req_ready = (mem_rand(4) != 0);
            if (mem_rd_req_valid && mem_rd_req_ready) begin
                a = mem_rd_req_addr;
                @(negedge clk);
                mem_rd_req_ready = 1'b0;
                serve_refill(a);
            end else if (mem_wr_req_valid && mem_wr_req_ready) begin
                a = mem_wr_req_addr;
                @(negedge clk);
                mem_wr_req_ready = 1'b0;
                serve_writeback(a);
            end else begin
                @(negedge clk);
            end
        end
    end

    initial begin : main_seq
        int start;
        int lat;
        bit saw_mem;
        dcache_pkg::addr_t a;
        dcache_pkg::word_t d;
        rst           = 1'b1;
        cpu_req_valid = 1'b0;
        cpu_req_write = 1'b0;
        cpu_req_addr  = '0;
        cpu_req_wdata = '0;
        cpu_req_wstrb = '0;
        cpu_rsp_ready = 1'b0;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        start = errors;
        check_cond("cpu_req_ready high after reset", cpu_req_ready);
        check_cond("valid outputs low after reset",
                   !(cpu_rsp_valid || mem_rd_req_valid || mem_rd_rsp_ready ||
                     mem_wr_req_valid || mem_wr_data_valid));
        report_test("reset state", start);

        start = errors;
        for (int i = 0; i < 16; i++) begin
            a = pick_addr();
            cpu_read(a, d, lat, saw_mem);
            check_word($sformatf("cold read of %h", a), d, init_word(a));
        end
        report_test("cold reads", start);

        start = errors;
        for (int i = 0; i < traffic_ops; i++) begin
            a = pick_addr();
            if (cpu_rand(2) == 0) begin
                cpu_write(a, cpu_word(), dcache_pkg::strb_t'(cpu_rand(16)));
            end else begin
                cpu_read(a, d, lat, saw_mem);
                check_word($sformatf("read of %h", a), d, shadow_word(a));
            end
        end
        report_test("random traffic", start);

        start = errors;
        for (int i = 0; i < repeat_ops; i++) begin
            a = pick_addr();
            cpu_read(a, d, lat, saw_mem);
            cpu_read(a, d, lat, saw_mem);
            check_word($sformatf("repeated read of %h", a), d, shadow_word(a));
            check_cond($sformatf("repeated read took %0d cycles, not 3", lat), lat == 3);
            check_cond("no memory request on a repeated read", !saw_mem);
        end
        report_test("repeated reads", start);

        start = errors;
        check_cond("traffic caused write-backs", wb_count > 0);
        foreach (wb_clean[la]) begin
            if (wb_clean[la]) begin
                for (int i = 0; i < 8; i++)
                    check_word($sformatf("memory word %h", la + 32'(i * 4)),
                               mem_word(la + 32'(i * 4)), shadow_word(la + 32'(i * 4)));
            end
        end
        report_test("memory image", start);

        $display("%0d checks, %0d errors, %0d write-backs", checks, errors, wb_count);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- project.f
hw/dcache_pkg.sv
hw/line_burst_buf.sv
hw/dcache_ways.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
tests/dcache_chk.sv
tests/dcache_tb.sv

//--- run.sh
#!/bin/sh
# build the dcache testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module dcache_tb -o dcache_sim \
    && ./obj_dir/dcache_sim > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; grep -q "=== PASS ===" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
